// File: hw/stq_pkg.sv
// Shared entry state and fixed field widths of the store queue.
// The word, bank and byte fields are fixed. The tag width and the entry
// count are module parameters.
`default_nettype none

package stq_pkg;

  // entry lifecycle
  typedef enum logic [1:0] {
    st_free      = 2'd0,
    st_wait_data = 2'd1,
    st_valid     = 2'd2,
    st_retired   = 2'd3
  } entry_state_e;

  // word offset, must be equal for a match
  localparam int WORD_W = 4;

  // bank mask, must share a bit for a match
  localparam int BANK_W = 2;

  // one bit per byte of the word
  localparam int BYTE_W = 4;

endpackage

`default_nettype wire

// File: hw/stq_alloc.sv
// Picks the lowest free entry for a new store. This block is purely combinational.
// A write strobe with no free entry yields an all-zero select and is dropped.
`timescale 1ns/1ps
`default_nettype none

module stq_alloc #(
  parameter int ENTRIES = 32
) (
  input  wire [ENTRIES-1:0]                        free_mask,
  input  wire                                      alloc_en,
  output logic                                     alloc_ready,
  output logic [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] alloc_idx,
  output logic [ENTRIES-1:0]                       alloc_onehot
);

  localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  logic found;

  // priority encoder, lowest index wins
  always_comb begin
    found        = 1'b0;
    alloc_idx    = '0;
    alloc_onehot = '0;
    for (int e = 0; e < ENTRIES; e++) begin
      if (free_mask[e] && !found) begin
        found           = 1'b1;
        alloc_idx       = IDX_W'(e);
        alloc_onehot[e] = alloc_en;
      end
    end
  end

  assign alloc_ready = found;

endmodule

`default_nettype wire

// File: hw/stq_entry.sv
// One store entry. It holds the lifecycle state, the stored fields, and the compare
// against every check port. The compare reads the state before the current edge.
// Strobe priority is free, then retire, then data, then write.
`timescale 1ns/1ps
`default_nettype none

module stq_entry #(
  parameter int ADDR_W    = 12,
  parameter int CHK_PORTS = 2
) (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire                                          wr_en,
  input  wire [ADDR_W-1:0]                             wr_tag,
  input  wire [stq_pkg::WORD_W-1:0]                    wr_word,
  input  wire [stq_pkg::BANK_W-1:0]                    wr_bank,
  input  wire [stq_pkg::BYTE_W-1:0]                    wr_bytes,
  input  wire                                          data_en,
  input  wire                                          retire_en,
  input  wire                                          free_en,
  input  wire [CHK_PORTS-1:0]                          chk_en,
  input  wire [CHK_PORTS-1:0][ADDR_W-1:0]              chk_tag,
  input  wire [CHK_PORTS-1:0][stq_pkg::WORD_W-1:0]     chk_word,
  input  wire [CHK_PORTS-1:0][stq_pkg::BANK_W-1:0]     chk_bank,
  input  wire [CHK_PORTS-1:0][stq_pkg::BYTE_W-1:0]     chk_bytes,
  output logic                                         is_free,
  output logic [CHK_PORTS-1:0]                         hit,
  output logic [CHK_PORTS-1:0]                         partial
);

  stq_pkg::entry_state_e state;

  logic [ADDR_W-1:0]          tag;
  logic [stq_pkg::WORD_W-1:0] word;
  logic [stq_pkg::BANK_W-1:0] bank;
  logic [stq_pkg::BYTE_W-1:0] bytes;

  logic                       live;
  logic [CHK_PORTS-1:0]       addr_hit;
  logic [CHK_PORTS-1:0]       covered;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stq_pkg::st_free;
    end else if (free_en) begin
      state <= stq_pkg::st_free;
    end else if (retire_en && state != stq_pkg::st_free) begin
      state <= stq_pkg::st_retired;
    end else if (data_en && state == stq_pkg::st_wait_data) begin
      state <= stq_pkg::st_valid;
    end else if (wr_en) begin
      // a new store waits for its data again
      state <= stq_pkg::st_wait_data;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag   <= wr_tag;
      word  <= wr_word;
      bank  <= wr_bank;
      bytes <= wr_bytes;
    end
  end

  // free and retired entries never match
  assign live    = (state == stq_pkg::st_wait_data) || (state == stq_pkg::st_valid);
  assign is_free = (state == stq_pkg::st_free);

  always_comb begin
    for (int p = 0; p < CHK_PORTS; p++) begin
      addr_hit[p] = chk_en[p] && live && (chk_tag[p] == tag) && (chk_word[p] == word) &&
                    ((chk_bank[p] & bank) != '0);
      covered[p]  = (chk_bytes[p] & ~bytes) == '0;
      hit[p]      = addr_hit[p] && (state == stq_pkg::st_valid) && covered[p];
      // overlap that cannot forward blocks the load
      partial[p]  = addr_hit[p] && !hit[p];
    end
  end

endmodule

`default_nettype wire

// File: hw/stq_entry_array.sv
// Generates the entries, decodes indexed commands into per-entry strobes and
// transposes the compare results into per-port masks.
// Index values at or above ENTRIES select no entry.
`timescale 1ns/1ps
`default_nettype none

module stq_entry_array #(
  parameter int ENTRIES   = 32,
  parameter int ADDR_W    = 12,
  parameter int CHK_PORTS = 2
) (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire [ENTRIES-1:0]                            alloc_onehot,
  input  wire [ADDR_W-1:0]                             alloc_tag,
  input  wire [stq_pkg::WORD_W-1:0]                    alloc_word,
  input  wire [stq_pkg::BANK_W-1:0]                    alloc_bank,
  input  wire [stq_pkg::BYTE_W-1:0]                    alloc_bytes,
  input  wire                                          data_en,
  input  wire [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] data_idx,
  input  wire                                          retire_en,
  input  wire [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] retire_idx,
  input  wire                                          free_en,
  input  wire [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] free_idx,
  input  wire [CHK_PORTS-1:0]                          chk_en,
  input  wire [CHK_PORTS-1:0][ADDR_W-1:0]              chk_tag,
  input  wire [CHK_PORTS-1:0][stq_pkg::WORD_W-1:0]     chk_word,
  input  wire [CHK_PORTS-1:0][stq_pkg::BANK_W-1:0]     chk_bank,
  input  wire [CHK_PORTS-1:0][stq_pkg::BYTE_W-1:0]     chk_bytes,
  output wire [ENTRIES-1:0]                            free_mask,
  output wire [CHK_PORTS-1:0][ENTRIES-1:0]             hit_mask,
  output wire [CHK_PORTS-1:0][ENTRIES-1:0]             partial_mask
);

  localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  for (genvar e = 0; e < ENTRIES; e++) begin : g_entry
    wire                 data_sel;
    wire                 retire_sel;
    wire                 free_sel;
    wire [CHK_PORTS-1:0] e_hit;
    wire [CHK_PORTS-1:0] e_partial;

    // index decode
    assign data_sel   = data_en && (data_idx == IDX_W'(e));
    assign retire_sel = retire_en && (retire_idx == IDX_W'(e));
    assign free_sel   = free_en && (free_idx == IDX_W'(e));

    stq_entry #(
      .ADDR_W    (ADDR_W),
      .CHK_PORTS (CHK_PORTS)
    ) u_entry (
      .clk       (clk),
      .rst       (rst),
      .wr_en     (alloc_onehot[e]),
      .wr_tag    (alloc_tag),
      .wr_word   (alloc_word),
      .wr_bank   (alloc_bank),
      .wr_bytes  (alloc_bytes),
      .data_en   (data_sel),
      .retire_en (retire_sel),
      .free_en   (free_sel),
      .chk_en    (chk_en),
      .chk_tag   (chk_tag),
      .chk_word  (chk_word),
      .chk_bank  (chk_bank),
      .chk_bytes (chk_bytes),
      .is_free   (free_mask[e]),
      .hit       (e_hit),
      .partial   (e_partial)
    );

    // entry-major to port-major
    for (genvar p = 0; p < CHK_PORTS; p++) begin : g_port
      assign hit_mask[p][e]     = e_hit[p];
      assign partial_mask[p][e] = e_partial[p];
    end
  end

endmodule

`default_nettype wire

// File: hw/stq_fwd_select.sv
// Reduces the per-entry compare results of each check port to registered
// results. The latency is one cycle and a new check is accepted every cycle.
// chk_hit is held low while any entry on that port is partial.
`timescale 1ns/1ps
`default_nettype none

module stq_fwd_select #(
  parameter int ENTRIES   = 32,
  parameter int CHK_PORTS = 2
) (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire [CHK_PORTS-1:0]                          chk_en,
  input  wire [CHK_PORTS-1:0][ENTRIES-1:0]             hit_mask,
  input  wire [CHK_PORTS-1:0][ENTRIES-1:0]             partial_mask,
  output logic [CHK_PORTS-1:0]                         chk_valid,
  output logic [CHK_PORTS-1:0]                         chk_hit,
  output logic [CHK_PORTS-1:0]                         chk_partial,
  output logic [CHK_PORTS-1:0][((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] chk_idx
);

  localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  logic [CHK_PORTS-1:0]            any_hit;
  logic [CHK_PORTS-1:0]            any_partial;
  logic [CHK_PORTS-1:0][IDX_W-1:0] low_idx;

  always_comb begin
    for (int p = 0; p < CHK_PORTS; p++) begin
      any_hit[p]     = |hit_mask[p];
      any_partial[p] = |partial_mask[p];
      low_idx[p]     = '0;
      // scan downward so the lowest hit is the last one kept
      for (int e = ENTRIES - 1; e >= 0; e--) begin
        if (hit_mask[p][e]) begin
          low_idx[p] = IDX_W'(e);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_valid   <= '0;
      chk_hit     <= '0;
      chk_partial <= '0;
      chk_idx     <= '0;
    end else begin
      for (int p = 0; p < CHK_PORTS; p++) begin
        chk_valid[p]   <= chk_en[p];
        chk_hit[p]     <= any_hit[p] && !any_partial[p];
        chk_partial[p] <= any_partial[p];
        chk_idx[p]     <= low_idx[p];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/store_queue_match.sv
// Store queue address match. All commands are single-cycle strobes acting at the
// next edge. Check results follow chk_en by exactly one cycle.
// alloc_en without alloc_ready is dropped, so the source must hold the store.
`timescale 1ns/1ps
`default_nettype none

module store_queue_match #(
  parameter int ENTRIES   = 32,
  parameter int ADDR_W    = 12,
  parameter int CHK_PORTS = 2
) (
  input  wire                                          clk,
  input  wire                                          rst,

  // allocation
  output wire                                          alloc_ready,
  output wire [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] alloc_idx,
  input  wire                                          alloc_en,
  input  wire [ADDR_W-1:0]                             alloc_tag,
  input  wire [stq_pkg::WORD_W-1:0]                    alloc_word,
  input  wire [stq_pkg::BANK_W-1:0]                    alloc_bank,
  input  wire [stq_pkg::BYTE_W-1:0]                    alloc_bytes,

  // indexed commands
  input  wire                                          data_en,
  input  wire [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] data_idx,
  input  wire                                          retire_en,
  input  wire [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] retire_idx,
  input  wire                                          free_en,
  input  wire [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] free_idx,

  // load checks
  input  wire [CHK_PORTS-1:0]                          chk_en,
  input  wire [CHK_PORTS-1:0][ADDR_W-1:0]              chk_tag,
  input  wire [CHK_PORTS-1:0][stq_pkg::WORD_W-1:0]     chk_word,
  input  wire [CHK_PORTS-1:0][stq_pkg::BANK_W-1:0]     chk_bank,
  input  wire [CHK_PORTS-1:0][stq_pkg::BYTE_W-1:0]     chk_bytes,
  output wire [CHK_PORTS-1:0]                          chk_valid,
  output wire [CHK_PORTS-1:0]                          chk_hit,
  output wire [CHK_PORTS-1:0]                          chk_partial,
  output wire [CHK_PORTS-1:0][((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] chk_idx
);

  wire [ENTRIES-1:0]                free_mask;
  wire [ENTRIES-1:0]                alloc_onehot;
  wire [CHK_PORTS-1:0][ENTRIES-1:0] hit_mask;
  wire [CHK_PORTS-1:0][ENTRIES-1:0] partial_mask;

  stq_alloc #(
    .ENTRIES (ENTRIES)
  ) u_alloc (
    .free_mask    (free_mask),
    .alloc_en     (alloc_en),
    .alloc_ready  (alloc_ready),
    .alloc_idx    (alloc_idx),
    .alloc_onehot (alloc_onehot)
  );

  stq_entry_array #(
    .ENTRIES   (ENTRIES),
    .ADDR_W    (ADDR_W),
    .CHK_PORTS (CHK_PORTS)
  ) u_array (
    .clk          (clk),
    .rst          (rst),
    .alloc_onehot (alloc_onehot),
    .alloc_tag    (alloc_tag),
    .alloc_word   (alloc_word),
    .alloc_bank   (alloc_bank),
    .alloc_bytes  (alloc_bytes),
    .data_en      (data_en),
    .data_idx     (data_idx),
    .retire_en    (retire_en),
    .retire_idx   (retire_idx),
    .free_en      (free_en),
    .free_idx     (free_idx),
    .chk_en       (chk_en),
    .chk_tag      (chk_tag),
    .chk_word     (chk_word),
    .chk_bank     (chk_bank),
    .chk_bytes    (chk_bytes),
    .free_mask    (free_mask),
    .hit_mask     (hit_mask),
    .partial_mask (partial_mask)
  );

  stq_fwd_select #(
    .ENTRIES   (ENTRIES),
    .CHK_PORTS (CHK_PORTS)
  ) u_select (
    .clk          (clk),
    .rst          (rst),
    .chk_en       (chk_en),
    .hit_mask     (hit_mask),
    .partial_mask (partial_mask),
    .chk_valid    (chk_valid),
    .chk_hit      (chk_hit),
    .chk_partial  (chk_partial),
    .chk_idx      (chk_idx)
  );

endmodule

`default_nettype wire

// File: testbench/stq_model.svh
// Reference model of the store entries, included inside the testbench module.
// It reads the driven inputs directly and uses ENTRIES, ADDR_W and CHK_PORTS
// from the including module.
`ifndef STQ_MODEL_SVH
`define STQ_MODEL_SVH

stq_pkg::entry_state_e      m_state [ENTRIES];
logic [ADDR_W-1:0]          m_tag   [ENTRIES];
logic [stq_pkg::WORD_W-1:0] m_word  [ENTRIES];
logic [stq_pkg::BANK_W-1:0] m_bank  [ENTRIES];
logic [stq_pkg::BYTE_W-1:0] m_bytes [ENTRIES];

// expected results, due one cycle after the check
logic [CHK_PORTS-1:0] exp_valid;
logic [CHK_PORTS-1:0] exp_hit;
logic [CHK_PORTS-1:0] exp_partial;
int                   exp_idx [CHK_PORTS];

task automatic model_reset();
  for (int e = 0; e < ENTRIES; e++) begin
    m_state[e] = stq_pkg::st_free;
    m_tag[e]   = '0;
    m_word[e]  = '0;
    m_bank[e]  = '0;
    m_bytes[e] = '0;
  end
  exp_valid   = '0;
  exp_hit     = '0;
  exp_partial = '0;
  for (int p = 0; p < CHK_PORTS; p++) begin
    exp_idx[p] = 0;
  end
endtask

// lowest free entry, -1 when none is left
function automatic int model_lowest_free();
  for (int e = 0; e < ENTRIES; e++) begin
    if (m_state[e] == stq_pkg::st_free) begin
      return e;
    end
  end
  return -1;
endfunction

// one load check against the state before the coming edge
task automatic model_check(input int p);
  logic addr_ok;
  logic full;
  logic any_full;
  logic any_part;
  int   low;
  any_full = 1'b0;
  any_part = 1'b0;
  low      = 0;
  for (int e = 0; e < ENTRIES; e++) begin
    addr_ok = chk_en[p] &&
              (m_state[e] == stq_pkg::st_wait_data || m_state[e] == stq_pkg::st_valid) &&
              chk_tag[p] == m_tag[e] && chk_word[p] == m_word[e] &&
              (chk_bank[p] & m_bank[e]) != '0;
    full = addr_ok && m_state[e] == stq_pkg::st_valid &&
           (chk_bytes[p] & m_bytes[e]) == chk_bytes[p];
    if (full && !any_full) begin
      low = e;
    end
    any_full = any_full || full;
    any_part = any_part || (addr_ok && !full);
  end
  exp_valid[p]   = chk_en[p];
  exp_hit[p]     = any_full && !any_part;
  exp_partial[p] = any_part;
  exp_idx[p]     = low;
endtask

// state after the coming edge, free before retire before data before allocate
task automatic model_step();
  stq_pkg::entry_state_e nxt [ENTRIES];
  int                    slot;
  slot = alloc_en ? model_lowest_free() : -1;
  for (int e = 0; e < ENTRIES; e++) begin
    nxt[e] = m_state[e];
    if (free_en && int'(free_idx) == e) begin
      nxt[e] = stq_pkg::st_free;
    end else if (retire_en && int'(retire_idx) == e && m_state[e] != stq_pkg::st_free) begin
      nxt[e] = stq_pkg::st_retired;
    end else if (data_en && int'(data_idx) == e && m_state[e] == stq_pkg::st_wait_data) begin
      nxt[e] = stq_pkg::st_valid;
    end else if (slot == e) begin
      nxt[e] = stq_pkg::st_wait_data;
    end
  end
  if (slot >= 0) begin
    m_tag[slot]   = alloc_tag;
    m_word[slot]  = alloc_word;
    m_bank[slot]  = alloc_bank;
    m_bytes[slot] = alloc_bytes;
  end
  for (int e = 0; e < ENTRIES; e++) begin
    m_state[e] = nxt[e];
  end
endtask

`endif

// File: testbench/tb_store_queue_match.sv
// Random test of the store queue match unit with 8 entries, 3-bit tags and two
// check ports. Inputs change 1 ns after each rising edge and every output is
// compared with the model in stq_model.svh. Stops at the first mismatch.
`timescale 1ns/1ps
`default_nettype none

module tb_store_queue_match;

  localparam int ENTRIES      = 8;
  localparam int ADDR_W       = 3;
  localparam int CHK_PORTS    = 2;
  localparam int IDX_W        = $clog2(ENTRIES);
  localparam int WORD_W       = stq_pkg::WORD_W;
  localparam int BANK_W       = stq_pkg::BANK_W;
  localparam int BYTE_W       = stq_pkg::BYTE_W;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_CYCLES   = 3000;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

  logic                              clk;
  logic                              rst;
  wire                               alloc_ready;
  wire  [IDX_W-1:0]                  alloc_idx;
  logic                              alloc_en;
  logic [ADDR_W-1:0]                 alloc_tag;
  logic [WORD_W-1:0]                 alloc_word;
  logic [BANK_W-1:0]                 alloc_bank;
  logic [BYTE_W-1:0]                 alloc_bytes;
  logic                              data_en;
  logic [IDX_W-1:0]                  data_idx;
  logic                              retire_en;
  logic [IDX_W-1:0]                  retire_idx;
  logic                              free_en;
  logic [IDX_W-1:0]                  free_idx;
  logic [CHK_PORTS-1:0]              chk_en;
  logic [CHK_PORTS-1:0][ADDR_W-1:0]  chk_tag;
  logic [CHK_PORTS-1:0][WORD_W-1:0]  chk_word;
  logic [CHK_PORTS-1:0][BANK_W-1:0]  chk_bank;
  logic [CHK_PORTS-1:0][BYTE_W-1:0]  chk_bytes;
  wire  [CHK_PORTS-1:0]              chk_valid;
  wire  [CHK_PORTS-1:0]              chk_hit;
  wire  [CHK_PORTS-1:0]              chk_partial;
  wire  [CHK_PORTS-1:0][IDX_W-1:0]   chk_idx;

  logic [31:0] rng;
  int          n_hit;
  int          n_partial;
  int          n_blocked;

  `include "stq_model.svh"

  store_queue_match #(
    .ENTRIES   (ENTRIES),
    .ADDR_W    (ADDR_W),
    .CHK_PORTS (CHK_PORTS)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .alloc_ready (alloc_ready),
    .alloc_idx   (alloc_idx),
    .alloc_en    (alloc_en),
    .alloc_tag   (alloc_tag),
    .alloc_word  (alloc_word),
    .alloc_bank  (alloc_bank),
    .alloc_bytes (alloc_bytes),
    .data_en     (data_en),
    .data_idx    (data_idx),
    .retire_en   (retire_en),
    .retire_idx  (retire_idx),
    .free_en     (free_en),
    .free_idx    (free_idx),
    .chk_en      (chk_en),
    .chk_tag     (chk_tag),
    .chk_word    (chk_word),
    .chk_bank    (chk_bank),
    .chk_bytes   (chk_bytes),
    .chk_valid   (chk_valid),
    .chk_hit     (chk_hit),
    .chk_partial (chk_partial),
    .chk_idx     (chk_idx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Error: the watchdog expired before the test finished");
    $display("Finished with errors");
    $fatal(1, "watchdog timeout");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic fail_value(input string name, input int expected, input int actual);
    $display("Error: time %0t signal %s expected %0h actual %0h", $time, name, expected,
             actual);
    $display("Finished with errors");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic fail_text(input string what);
    $display("Error: %s", what);
    $display("Finished with errors");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic idle_inputs();
    alloc_en    = 1'b0;
    alloc_tag   = '0;
    alloc_word  = '0;
    alloc_bank  = '0;
    alloc_bytes = '0;
    data_en     = 1'b0;
    data_idx    = '0;
    retire_en   = 1'b0;
    retire_idx  = '0;
    free_en     = 1'b0;
    free_idx    = '0;
    chk_en      = '0;
    chk_tag     = '0;
    chk_word    = '0;
    chk_bank    = '0;
    chk_bytes   = '0;
  endtask

  // frees are rare in even phases so the queue fills up and frequent in odd ones
  task automatic drive_random(input int cycle);
    int   pick;
    logic drain;
    drain       = ((cycle / 400) % 2) == 1;
    alloc_en    = (next_rand() % 4) != 0;
    alloc_tag   = ADDR_W'(next_rand());
    alloc_word  = WORD_W'(next_rand() % 2);
    alloc_bank  = BANK_W'((next_rand() % 3) + 1);
    alloc_bytes = BYTE_W'(next_rand());
    data_en     = (next_rand() % 3) == 0;
    data_idx    = IDX_W'(next_rand());
    retire_en   = (next_rand() % 8) == 0;
    retire_idx  = IDX_W'(next_rand());
    free_en     = drain ? ((next_rand() % 2) == 0) : ((next_rand() % 12) == 0);
    free_idx    = IDX_W'(next_rand());
    for (int p = 0; p < CHK_PORTS; p++) begin
      chk_en[p] = (next_rand() % 4) != 0;
      pick      = int'(next_rand() % ENTRIES);
      // mostly aim at a stored address so matches are common
      if ((next_rand() % 4) != 0) begin
        chk_tag[p]   = m_tag[pick];
        chk_word[p]  = m_word[pick];
        chk_bytes[p] = ((next_rand() % 2) == 0) ? (m_bytes[pick] & BYTE_W'(next_rand())) :
                       BYTE_W'(next_rand());
      end else begin
        chk_tag[p]   = ADDR_W'(next_rand());
        chk_word[p]  = WORD_W'(next_rand() % 2);
        chk_bytes[p] = BYTE_W'(next_rand());
      end
      chk_bank[p] = BANK_W'(next_rand() % 4);
    end
  endtask

  task automatic check_outputs();
    logic exp_ready;
    exp_ready = model_lowest_free() >= 0;
    assert (alloc_ready == exp_ready)
      else fail_value("alloc_ready", int'(exp_ready), int'(alloc_ready));
    if (exp_ready) begin
      assert (int'(alloc_idx) == model_lowest_free())
        else fail_value("alloc_idx", model_lowest_free(), int'(alloc_idx));
    end
    for (int p = 0; p < CHK_PORTS; p++) begin
      assert (chk_valid[p] == exp_valid[p])
        else fail_value($sformatf("chk_valid[%0d]", p), int'(exp_valid[p]), int'(chk_valid[p]));
      assert (chk_hit[p] == exp_hit[p])
        else fail_value($sformatf("chk_hit[%0d]", p), int'(exp_hit[p]), int'(chk_hit[p]));
      assert (chk_partial[p] == exp_partial[p])
        else fail_value($sformatf("chk_partial[%0d]", p), int'(exp_partial[p]),
                        int'(chk_partial[p]));
      assert (int'(chk_idx[p]) == exp_idx[p])
        else fail_value($sformatf("chk_idx[%0d]", p), exp_idx[p], int'(chk_idx[p]));
    end
  endtask

  initial begin
    rng       = 32'hb677;
    n_hit     = 0;
    n_partial = 0;
    n_blocked = 0;
    rst       = 1'b1;
    idle_inputs();
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    // state straight out of reset
    check_outputs();

    for (int c = 0; c < NUM_CYCLES; c++) begin
      drive_random(c);
      for (int p = 0; p < CHK_PORTS; p++) begin
        model_check(p);
        n_hit     += int'(exp_hit[p]);
        n_partial += int'(exp_partial[p]);
      end
      if (alloc_en && model_lowest_free() < 0) begin
        n_blocked++;
      end
      model_step();
      @(posedge clk);
      #1;
      check_outputs();
    end
    idle_inputs();

    assert (n_hit > 0) else fail_text("no check ever produced a full match");
    assert (n_partial > 0) else fail_text("no check ever produced a partial match");
    assert (n_blocked > 0) else fail_text("the queue never filled up during allocation");

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+testbench
hw/stq_pkg.sv
hw/stq_alloc.sv
hw/stq_entry.sv
hw/stq_entry_array.sv
hw/stq_fwd_select.sv
hw/store_queue_match.sv
testbench/tb_store_queue_match.sv

// File: run.sh
#!/bin/sh
# Builds the store queue testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_store_queue_match -f flist.f --Mdir obj_dir

status=0
out=$(./obj_dir/Vtb_store_queue_match 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "simulation failed, exit status $status"
exit 1
